// File: Makefile
# Verilator flow for the KSK AXI reader

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_ksk_axi_reader
RTL_TOP   ?= ksk_axi_reader
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --timing --timescale $(TIMESCALE)

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: ksk_axi_reader.sv
`include "ksk_rd_params.svh"

module ksk_axi_reader (
  input  logic                          clk,
  input  logic                          s_rst_n,

  input  logic [`KSK_AXI_ADD_W-1:0]     ksk_mem_addr,

  // AXI4 read address channel
  output logic [3:0]                    m_axi4_arid,
  output logic [`KSK_AXI_ADD_W-1:0]     m_axi4_araddr,
  output logic [7:0]                    m_axi4_arlen,
  output logic [2:0]                    m_axi4_arsize,
  output logic [1:0]                    m_axi4_arburst,
  output logic                          m_axi4_arvalid,
  input  logic                          m_axi4_arready,

  // AXI4 read data channel
  input  logic [`KSK_AXI_DATA_W-1:0]    m_axi4_rdata,
  input  logic                          m_axi4_rlast,
  input  logic                          m_axi4_rvalid,
  output logic                          m_axi4_rready,

  // Cache control
  input  logic                          cctrl_rd_vld,
  output logic                          cctrl_rd_rdy,
  input  ksk_rd_pkg::ksk_read_cmd_t     cctrl_rd_cmd,

  // KSK manager
  output logic [`KSK_CUT_NB-1:0]        ksk_mgr_wr_en,
  output logic [`KSK_CUT_NB*`KSK_CUT_FCOEF_NB*`KSK_COEF_W-1:0] ksk_mgr_wr_data,
  output logic [`KSK_RAM_ADD_W-1:0]     ksk_mgr_wr_add,
  output logic [`KSK_X_W-1:0]           ksk_mgr_wr_x_idx,
  output logic [`KSK_SLOT_W-1:0]        ksk_mgr_wr_slot,
  output logic [`KSK_LOOP_W-1:0]        ksk_mgr_wr_ks_loop,

  output logic                          rd_slot_done,
  output logic [`KSK_SLOT_W-1:0]        rd_slot_id
);

  logic                        dec_vld;
  logic                        dec_rdy;
  ksk_rd_pkg::ksk_start_cmd_t  dec_cmd;

  logic                        recp_in_vld;
  logic                        recp_in_rdy;
  ksk_rd_pkg::ksk_read_cmd_t   recp_in_cmd;
  logic                        recp_out_vld;
  logic                        recp_out_rdy;
  ksk_rd_pkg::ksk_read_cmd_t   recp_out_cmd;

  logic                        ar_vld;
  logic                        ar_rdy;
  ksk_rd_pkg::ksk_ar_t         ar_beat;
  ksk_rd_pkg::ksk_ar_t         ar_out;

  ksk_rd_pkg::ksk_r_t          r_in;
  ksk_rd_pkg::ksk_r_t          r_beat;
  logic                        r_vld;
  logic                        r_rdy;

  // Single ID, full-width INCR bursts
  assign m_axi4_arid    = '0;
  assign m_axi4_arsize  = 3'(`KSK_AXI_BYTES_W);
  assign m_axi4_arburst = 2'b01;
  assign m_axi4_araddr  = ar_out.araddr;
  assign m_axi4_arlen   = ar_out.arlen;

  assign r_in.rdata = m_axi4_rdata;
  assign r_in.rlast = m_axi4_rlast;

  ksk_rd_cmd_decode u_cmd_decode (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .cctrl_rd_vld (cctrl_rd_vld),
    .cctrl_rd_rdy (cctrl_rd_rdy),
    .cctrl_rd_cmd (cctrl_rd_cmd),
    .ksk_mem_addr (ksk_mem_addr),
    .dec_vld      (dec_vld),
    .dec_rdy      (dec_rdy),
    .dec_cmd      (dec_cmd)
  );

  ksk_rd_req_gen u_req_gen (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .dec_vld  (dec_vld),
    .dec_rdy  (dec_rdy),
    .dec_cmd  (dec_cmd),
    .recp_vld (recp_in_vld),
    .recp_rdy (recp_in_rdy),
    .recp_cmd (recp_in_cmd),
    .ar_vld   (ar_vld),
    .ar_rdy   (ar_rdy),
    .ar_beat  (ar_beat)
  );

  // Commands whose data is still expected
  ksk_rd_fifo #(
    .data_t (ksk_rd_pkg::ksk_read_cmd_t),
    .DEPTH  (`KSK_RECP_DEPTH)
  ) u_recp_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (recp_in_cmd),
    .in_vld   (recp_in_vld),
    .in_rdy   (recp_in_rdy),
    .out_data (recp_out_cmd),
    .out_vld  (recp_out_vld),
    .out_rdy  (recp_out_rdy)
  );

  ksk_rd_fifo #(
    .data_t (ksk_rd_pkg::ksk_ar_t),
    .DEPTH  (2)
  ) u_ar_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (ar_beat),
    .in_vld   (ar_vld),
    .in_rdy   (ar_rdy),
    .out_data (ar_out),
    .out_vld  (m_axi4_arvalid),
    .out_rdy  (m_axi4_arready)
  );

  ksk_rd_fifo #(
    .data_t (ksk_rd_pkg::ksk_r_t),
    .DEPTH  (2)
  ) u_r_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (r_in),
    .in_vld   (m_axi4_rvalid),
    .in_rdy   (m_axi4_rready),
    .out_data (r_beat),
    .out_vld  (r_vld),
    .out_rdy  (r_rdy)
  );

  ksk_rd_unpack u_unpack (
    .clk                (clk),
    .s_rst_n            (s_rst_n),
    .r_vld              (r_vld),
    .r_rdy              (r_rdy),
    .r_beat             (r_beat),
    .recp_vld           (recp_out_vld),
    .recp_rdy           (recp_out_rdy),
    .recp_cmd           (recp_out_cmd),
    .ksk_mgr_wr_en      (ksk_mgr_wr_en),
    .ksk_mgr_wr_data    (ksk_mgr_wr_data),
    .ksk_mgr_wr_add     (ksk_mgr_wr_add),
    .ksk_mgr_wr_x_idx   (ksk_mgr_wr_x_idx),
    .ksk_mgr_wr_slot    (ksk_mgr_wr_slot),
    .ksk_mgr_wr_ks_loop (ksk_mgr_wr_ks_loop),
    .rd_slot_done       (rd_slot_done),
    .rd_slot_id         (rd_slot_id)
  );

endmodule

// File: ksk_rd_cmd_decode.sv
`include "ksk_rd_params.svh"

module ksk_rd_cmd_decode (
  input  logic                           clk,
  input  logic                           s_rst_n,

  // Cache control side
  input  logic                           cctrl_rd_vld,
  output logic                           cctrl_rd_rdy,
  input  ksk_rd_pkg::ksk_read_cmd_t      cctrl_rd_cmd,
  input  logic [`KSK_AXI_ADD_W-1:0]      ksk_mem_addr,

  // To the request generator
  output logic                           dec_vld,
  input  logic                           dec_rdy,
  output ksk_rd_pkg::ksk_start_cmd_t     dec_cmd
);

  localparam int ADD_W = `KSK_AXI_ADD_W;

  logic             run;
  logic             take;
  logic [ADD_W-1:0] loop_ofs;

  // Offset of the ks_loop slice from the key base
  assign loop_ofs = ADD_W'(cctrl_rd_cmd.ks_loop) * ADD_W'(`KSK_SLICE_BYTES);

  // One-entry stage, free when empty or when its content leaves
  assign cctrl_rd_rdy = run & (~dec_vld | dec_rdy);
  assign take         = cctrl_rd_vld & cctrl_rd_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      run     <= 1'b0;
      dec_vld <= 1'b0;
    end else begin
      run <= 1'b1;
      if (cctrl_rd_rdy) begin
        dec_vld <= cctrl_rd_vld;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dec_cmd.cmd <= cctrl_rd_cmd;
      dec_cmd.add <= ksk_mem_addr + loop_ofs;
    end
  end

endmodule

// File: ksk_rd_fifo.sv
`include "ksk_rd_params.svh"

module ksk_rd_fifo #(
  parameter type data_t = logic,
  parameter int  DEPTH  = 2
) (
  input  logic  clk,
  input  logic  s_rst_n,

  input  data_t in_data,
  input  logic  in_vld,
  output logic  in_rdy,

  output data_t out_data,
  output logic  out_vld,
  input  logic  out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_d;
  logic             wr;
  logic             rd;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr       = in_vld & in_rdy;
  assign rd       = out_vld & out_rdy;
  assign out_vld  = cnt != '0;
  assign out_data = mem[rd_ptr];

  always_comb begin
    cnt_d = cnt;
    if (wr && !rd) cnt_d = cnt + 1'b1;
    else if (rd && !wr) cnt_d = cnt - 1'b1;
  end

  // Ready is registered, so it stays low while in reset
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      cnt    <= '0;
      in_rdy <= 1'b0;
    end else begin
      if (wr) wr_ptr <= ptr_inc(wr_ptr);
      if (rd) rd_ptr <= ptr_inc(rd_ptr);
      cnt    <= cnt_d;
      in_rdy <= cnt_d != CNT_W'(DEPTH);
    end
  end

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= in_data;
  end

endmodule

// File: ksk_rd_params.svh
`ifndef KSK_RD_PARAMS_SVH
`define KSK_RD_PARAMS_SVH

// AXI4 read bus
`define KSK_AXI_DATA_W    128
`define KSK_AXI_ADD_W     32
`define KSK_AXI_BYTES_W   4
`define KSK_PAGE_BYTES_W  12

// Key coefficient layout inside an AXI word
`define KSK_COEF_W        16
`define KSK_COEF_PER_WORD 8
`define KSK_CUT_NB        2
`define KSK_CUT_FCOEF_NB  2
`define KSK_WR_PER_WORD   (`KSK_COEF_PER_WORD / (`KSK_CUT_NB * `KSK_CUT_FCOEF_NB))

// Slice geometry
`define KSK_WORD_PER_COL  3
`define KSK_LBX           4
`define KSK_LBX_LAST      3
`define KSK_COL_NB        16
`define KSK_SLOT_NB       4
`define KSK_SLOT_DEPTH    (`KSK_LBX * `KSK_WORD_PER_COL * `KSK_WR_PER_WORD)
`define KSK_SLICE_BYTES   (`KSK_LBX * `KSK_WORD_PER_COL * (`KSK_AXI_DATA_W / 8))
`define KSK_RECP_DEPTH    4

`define KSK_SLOT_W        $clog2(`KSK_SLOT_NB)
`define KSK_LOOP_W        $clog2(`KSK_COL_NB)
`define KSK_X_W           $clog2(`KSK_LBX)
`define KSK_RAM_ADD_W     $clog2(`KSK_SLOT_NB * `KSK_SLOT_DEPTH)

`endif

// File: ksk_rd_pkg.sv
`include "ksk_rd_params.svh"

package ksk_rd_pkg;

  // Read command from the cache control
  typedef struct packed {
    logic [`KSK_SLOT_W-1:0] slot_id;
    logic [`KSK_LOOP_W-1:0] ks_loop;
  } ksk_read_cmd_t;

  // Command with its first byte address in memory
  typedef struct packed {
    ksk_read_cmd_t             cmd;
    logic [`KSK_AXI_ADD_W-1:0] add;
  } ksk_start_cmd_t;

  // Variable part of an AR beat
  typedef struct packed {
    logic [`KSK_AXI_ADD_W-1:0] araddr;
    logic [7:0]                arlen;
  } ksk_ar_t;

  // R beat as stored in the reception FIFO
  typedef struct packed {
    logic [`KSK_AXI_DATA_W-1:0] rdata;
    logic                       rlast;
  } ksk_r_t;

endpackage

// File: ksk_rd_req_gen.sv
`include "ksk_rd_params.svh"

module ksk_rd_req_gen (
  input  logic                        clk,
  input  logic                        s_rst_n,

  input  logic                        dec_vld,
  output logic                        dec_rdy,
  input  ksk_rd_pkg::ksk_start_cmd_t  dec_cmd,

  // Reception command FIFO push
  output logic                        recp_vld,
  input  logic                        recp_rdy,
  output ksk_rd_pkg::ksk_read_cmd_t   recp_cmd,

  // AR FIFO push
  output logic                        ar_vld,
  input  logic                        ar_rdy,
  output ksk_rd_pkg::ksk_ar_t         ar_beat
);

  localparam int ADD_W      = `KSK_AXI_ADD_W;
  localparam int X_W        = `KSK_X_W;
  localparam int LOOP_W     = `KSK_LOOP_W;
  localparam int WR_W       = $clog2(`KSK_WORD_PER_COL + 1);
  localparam int PG_W       = `KSK_PAGE_BYTES_W - `KSK_AXI_BYTES_W + 1;
  localparam int PAGE_WORDS = 1 << (`KSK_PAGE_BYTES_W - `KSK_AXI_BYTES_W);

  logic             sent;
  logic [ADD_W-1:0] cur_add;
  logic [X_W-1:0]   x_idx;
  logic [X_W-1:0]   x_max;
  logic [WR_W-1:0]  word_remain;
  logic [PG_W-1:0]  remain_ext;
  logic [PG_W-1:0]  page_words;
  logic [PG_W-1:0]  word_nb;
  logic             last_word;
  logic             last_x;
  logic             send;

  // ------------------------------------------------------------------------
  // Burst sizing
  // ------------------------------------------------------------------------
  assign remain_ext = PG_W'(word_remain);
  assign page_words = PG_W'(PAGE_WORDS)
                    - PG_W'(cur_add[`KSK_PAGE_BYTES_W-1:`KSK_AXI_BYTES_W]);
  // Stop at the column end or at the 4 KB page end
  assign word_nb    = (page_words < remain_ext) ? page_words : remain_ext;
  assign last_word  = remain_ext == word_nb;

  // Last ks_loop of the key holds fewer columns
  assign x_max  = (dec_cmd.cmd.ks_loop == LOOP_W'(`KSK_COL_NB - 1)) ?
                  X_W'(`KSK_LBX_LAST - 1) : X_W'(`KSK_LBX - 1);
  assign last_x = x_idx == x_max;

  // ------------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------------
  // Phase one pushes the command, phase two sends the bursts
  assign recp_vld = dec_vld & ~sent;
  assign recp_cmd = dec_cmd.cmd;

  assign ar_vld          = dec_vld & sent;
  assign ar_beat.araddr  = cur_add;
  assign ar_beat.arlen   = 8'(word_nb - PG_W'(1));
  assign send            = ar_vld & ar_rdy;

  assign dec_rdy = send & last_word & last_x;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sent        <= 1'b0;
      x_idx       <= '0;
      word_remain <= WR_W'(`KSK_WORD_PER_COL);
    end else begin
      if (dec_rdy) sent <= 1'b0;
      else if (recp_vld && recp_rdy) sent <= 1'b1;

      if (send) begin
        word_remain <= last_word ? WR_W'(`KSK_WORD_PER_COL) : WR_W'(remain_ext - word_nb);
        if (last_word) x_idx <= last_x ? '0 : x_idx + 1'b1;
      end
    end
  end

  // Start address is loaded while the command waits for its push
  always_ff @(posedge clk) begin
    if (recp_vld) cur_add <= dec_cmd.add;
    else if (send) cur_add <= cur_add + (ADD_W'(word_nb) << `KSK_AXI_BYTES_W);
  end

endmodule

// File: ksk_rd_unpack.sv
`include "ksk_rd_params.svh"

module ksk_rd_unpack (
  input  logic                          clk,
  input  logic                          s_rst_n,

  input  logic                          r_vld,
  output logic                          r_rdy,
  input  ksk_rd_pkg::ksk_r_t            r_beat,

  input  logic                          recp_vld,
  output logic                          recp_rdy,
  input  ksk_rd_pkg::ksk_read_cmd_t     recp_cmd,

  // KSK manager RAM
  output logic [`KSK_CUT_NB-1:0]        ksk_mgr_wr_en,
  output logic [`KSK_CUT_NB*`KSK_CUT_FCOEF_NB*`KSK_COEF_W-1:0] ksk_mgr_wr_data,
  output logic [`KSK_RAM_ADD_W-1:0]     ksk_mgr_wr_add,
  output logic [`KSK_X_W-1:0]           ksk_mgr_wr_x_idx,
  output logic [`KSK_SLOT_W-1:0]        ksk_mgr_wr_slot,
  output logic [`KSK_LOOP_W-1:0]        ksk_mgr_wr_ks_loop,

  output logic                          rd_slot_done,
  output logic [`KSK_SLOT_W-1:0]        rd_slot_id
);

  localparam int PROC_W = `KSK_CUT_NB * `KSK_CUT_FCOEF_NB * `KSK_COEF_W;
  localparam int X_W    = `KSK_X_W;
  localparam int LOOP_W = `KSK_LOOP_W;
  localparam int ADD_W  = `KSK_RAM_ADD_W;
  localparam int WC_W   = $clog2(`KSK_WORD_PER_COL);
  localparam int SR_W   = (`KSK_WR_PER_WORD > 1) ? $clog2(`KSK_WR_PER_WORD) : 1;
  localparam int ELT_W  = $clog2(`KSK_SLOT_DEPTH);

  logic [WC_W-1:0]            word_cnt;
  logic [X_W-1:0]             x_cnt;
  logic [X_W-1:0]             x_max;
  logic                       last_word;
  logic                       last_x;
  logic                       pop;

  logic [`KSK_AXI_DATA_W-1:0] sr_data;
  logic [SR_W-1:0]            sr_cnt;
  logic                       sr_avail;
  logic                       sr_last;

  ksk_rd_pkg::ksk_read_cmd_t  r1_cmd;
  logic [X_W-1:0]             r1_x_idx;
  logic                       r1_slice_last;
  logic [ADD_W-1:0]           r1_add_ofs;
  logic [ELT_W-1:0]           slot_elt;
  logic                       slice_end;

  // ------------------------------------------------------------------------
  // Word and column counting against the command
  // ------------------------------------------------------------------------
  assign x_max     = (recp_cmd.ks_loop == LOOP_W'(`KSK_COL_NB - 1)) ?
                     X_W'(`KSK_LBX_LAST - 1) : X_W'(`KSK_LBX - 1);
  assign last_word = word_cnt == WC_W'(`KSK_WORD_PER_COL - 1);
  assign last_x    = x_cnt == x_max;

  // New word only once the previous one is fully written
  assign r_rdy    = recp_vld & (~sr_avail | sr_last);
  assign pop      = r_vld & r_rdy;
  assign recp_rdy = pop & last_word & last_x;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      word_cnt <= '0;
      x_cnt    <= '0;
    end else if (pop) begin
      word_cnt <= last_word ? '0 : word_cnt + 1'b1;
      if (last_word) x_cnt <= last_x ? '0 : x_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Shift register, one write per slot
  // ------------------------------------------------------------------------
  assign sr_last   = sr_cnt == SR_W'(`KSK_WR_PER_WORD - 1);
  assign slice_end = sr_avail & sr_last & r1_slice_last;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sr_cnt   <= '0;
      sr_avail <= 1'b0;
      slot_elt <= '0;
    end else begin
      if (pop) sr_avail <= 1'b1;
      else if (sr_avail && sr_last) sr_avail <= 1'b0;

      if (sr_avail) begin
        sr_cnt   <= sr_last ? '0 : sr_cnt + 1'b1;
        slot_elt <= slice_end ? '0 : slot_elt + 1'b1;
      end
    end
  end

  // Word context kept beside the data
  always_ff @(posedge clk) begin
    if (pop) begin
      sr_data       <= r_beat.rdata;
      r1_cmd        <= recp_cmd;
      r1_x_idx      <= x_cnt;
      r1_slice_last <= last_word & last_x;
      r1_add_ofs    <= ADD_W'(recp_cmd.slot_id) * ADD_W'(`KSK_SLOT_DEPTH);
    end else if (sr_avail) begin
      sr_data <= sr_data >> PROC_W;
    end
  end

  // ------------------------------------------------------------------------
  // Registered manager writes
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ksk_mgr_wr_en <= '0;
      rd_slot_done  <= 1'b0;
    end else begin
      // All cuts share the same word
      ksk_mgr_wr_en <= {`KSK_CUT_NB{sr_avail}};
      rd_slot_done  <= slice_end;
    end
  end

  always_ff @(posedge clk) begin
    ksk_mgr_wr_data    <= sr_data[PROC_W-1:0];
    ksk_mgr_wr_add     <= r1_add_ofs + ADD_W'(slot_elt);
    ksk_mgr_wr_x_idx   <= r1_x_idx;
    ksk_mgr_wr_slot    <= r1_cmd.slot_id;
    ksk_mgr_wr_ks_loop <= r1_cmd.ks_loop;
    rd_slot_id         <= r1_cmd.slot_id;
  end

endmodule

// File: tb_axi_mem_model.sv
`include "ksk_rd_params.svh"

module tb_axi_mem_model (
  input  logic                       clk,
  input  logic                       s_rst_n,

  input  logic [`KSK_AXI_ADD_W-1:0]  araddr,
  input  logic [7:0]                 arlen,
  input  logic                       arvalid,
  output logic                       arready,

  output logic [`KSK_AXI_DATA_W-1:0] rdata,
  output logic                       rlast,
  output logic                       rvalid,
  input  logic                       rready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADD_W      = `KSK_AXI_ADD_W;
  localparam int DATA_W     = `KSK_AXI_DATA_W;
  localparam int COEF_W     = `KSK_COEF_W;
  localparam int WORD_BYTES = `KSK_AXI_DATA_W / 8;

  logic [31:0]       lcg_state = 32'hd737c4ae;
  logic              arready_q = 1'b0;
  logic              rvalid_q  = 1'b0;
  logic              rlast_q   = 1'b0;
  logic [DATA_W-1:0] rdata_q   = '0;
  logic              r_taken   = 1'b0;
  int                beat_idx  = 0;
  logic [ADD_W-1:0]  burst_add [$];
  logic [7:0]        burst_len [$];

  assign arready = arready_q;
  assign rvalid  = rvalid_q;
  assign rlast   = rlast_q;
  assign rdata   = rdata_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Coefficient k of the word at byte address a holds a/2 + k
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADD_W-1:0] a);
    logic [DATA_W-1:0] w;
    w = '0;
    for (int k = 0; k < `KSK_COEF_PER_WORD; k++) begin
      w[k*COEF_W +: COEF_W] = COEF_W'((a >> 1) + ADD_W'(k));
    end
    return w;
  endfunction

  // Bursts queued and beats retired on the rising edge
  always @(posedge clk) begin
    r_taken = 1'b0;
    if (!s_rst_n) begin
      burst_add.delete();
      burst_len.delete();
      beat_idx = 0;
    end else begin
      if (arvalid && arready_q) begin
        burst_add.push_back(araddr);
        burst_len.push_back(arlen);
      end
      if (rvalid_q && rready) begin
        r_taken = 1'b1;
        if (rlast_q) begin
          void'(burst_add.pop_front());
          void'(burst_len.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  // Outputs change on the falling edge, with random gaps
  always @(negedge clk) begin
    lcg_state = lcg_next(lcg_state);
    if (!s_rst_n) begin
      arready_q = 1'b0;
      rvalid_q  = 1'b0;
    end else begin
      if (r_taken) rvalid_q = 1'b0;
      arready_q = lcg_state[31:30] != 2'b00;
      if (!rvalid_q && burst_add.size() != 0 && lcg_state[28:27] != 2'b00) begin
        rvalid_q = 1'b1;
        rdata_q  = mem_word(burst_add[0] + ADD_W'(beat_idx * WORD_BYTES));
        rlast_q  = beat_idx == int'(burst_len[0]);
      end
    end
  end

endmodule

// File: tb_ksk_axi_reader.sv
`include "ksk_rd_params.svh"

module tb_ksk_axi_reader;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADD_W      = `KSK_AXI_ADD_W;
  localparam int COEF_W     = `KSK_COEF_W;
  localparam int FC         = `KSK_CUT_FCOEF_NB;
  localparam int WPC        = `KSK_WORD_PER_COL;
  localparam int WPW        = `KSK_WR_PER_WORD;
  localparam int WR_W       = `KSK_CUT_NB * `KSK_CUT_FCOEF_NB * `KSK_COEF_W;
  localparam int SLOT_W     = `KSK_SLOT_W;
  localparam int LOOP_W     = `KSK_LOOP_W;
  localparam int X_W        = `KSK_X_W;
  localparam int RAM_ADD_W  = `KSK_RAM_ADD_W;
  localparam int WORD_BYTES = `KSK_AXI_DATA_W / 8;
  localparam int PAGE_BYTES = 1 << `KSK_PAGE_BYTES_W;
  localparam int WAIT_LIMIT = 5000;
  // Close to a page end so that some slices get split
  localparam logic [ADD_W-1:0] BASE_ADD = 32'h0001_0f00;

  typedef struct packed {
    logic [ADD_W-1:0] add;
    logic [7:0]       len;
  } ar_rec_t;

  typedef struct packed {
    logic [WR_W-1:0]      data;
    logic [RAM_ADD_W-1:0] add;
    logic [X_W-1:0]       x_idx;
    logic [SLOT_W-1:0]    slot;
    logic [LOOP_W-1:0]    ks_loop;
  } wr_rec_t;

  logic                       clk = 1'b0;
  logic                       s_rst_n;
  logic [ADD_W-1:0]           ksk_mem_addr;
  logic [3:0]                 m_axi4_arid;
  logic [ADD_W-1:0]           m_axi4_araddr;
  logic [7:0]                 m_axi4_arlen;
  logic [2:0]                 m_axi4_arsize;
  logic [1:0]                 m_axi4_arburst;
  logic                       m_axi4_arvalid;
  logic                       m_axi4_arready;
  logic [`KSK_AXI_DATA_W-1:0] m_axi4_rdata;
  logic                       m_axi4_rlast;
  logic                       m_axi4_rvalid;
  logic                       m_axi4_rready;
  logic                       cctrl_rd_vld;
  logic                       cctrl_rd_rdy;
  ksk_rd_pkg::ksk_read_cmd_t  cctrl_rd_cmd;
  logic [`KSK_CUT_NB-1:0]     ksk_mgr_wr_en;
  logic [WR_W-1:0]            ksk_mgr_wr_data;
  logic [RAM_ADD_W-1:0]       ksk_mgr_wr_add;
  logic [X_W-1:0]             ksk_mgr_wr_x_idx;
  logic [SLOT_W-1:0]          ksk_mgr_wr_slot;
  logic [LOOP_W-1:0]          ksk_mgr_wr_ks_loop;
  logic                       rd_slot_done;
  logic [SLOT_W-1:0]          rd_slot_id;

  ar_rec_t           exp_ar [$];
  wr_rec_t           exp_wr [$];
  logic [SLOT_W-1:0] exp_done_slot [$];
  int                exp_done_cnt [$];
  ar_rec_t           ar_exp;
  wr_rec_t           wr_exp;
  logic [ADD_W-1:0]  burst_last;
  logic [31:0]       seed = 32'hd737c4ae;
  int                wr_seen = 0;
  int                cmd_acc = 0;
  int                done_seen = 0;
  int                max_in_flight = 0;

  always #2 clk = ~clk;

  ksk_axi_reader u_dut (
    .clk                (clk),
    .s_rst_n            (s_rst_n),
    .ksk_mem_addr       (ksk_mem_addr),
    .m_axi4_arid        (m_axi4_arid),
    .m_axi4_araddr      (m_axi4_araddr),
    .m_axi4_arlen       (m_axi4_arlen),
    .m_axi4_arsize      (m_axi4_arsize),
    .m_axi4_arburst     (m_axi4_arburst),
    .m_axi4_arvalid     (m_axi4_arvalid),
    .m_axi4_arready     (m_axi4_arready),
    .m_axi4_rdata       (m_axi4_rdata),
    .m_axi4_rlast       (m_axi4_rlast),
    .m_axi4_rvalid      (m_axi4_rvalid),
    .m_axi4_rready      (m_axi4_rready),
    .cctrl_rd_vld       (cctrl_rd_vld),
    .cctrl_rd_rdy       (cctrl_rd_rdy),
    .cctrl_rd_cmd       (cctrl_rd_cmd),
    .ksk_mgr_wr_en      (ksk_mgr_wr_en),
    .ksk_mgr_wr_data    (ksk_mgr_wr_data),
    .ksk_mgr_wr_add     (ksk_mgr_wr_add),
    .ksk_mgr_wr_x_idx   (ksk_mgr_wr_x_idx),
    .ksk_mgr_wr_slot    (ksk_mgr_wr_slot),
    .ksk_mgr_wr_ks_loop (ksk_mgr_wr_ks_loop),
    .rd_slot_done       (rd_slot_done),
    .rd_slot_id         (rd_slot_id)
  );

  tb_axi_mem_model u_mem (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .araddr  (m_axi4_araddr),
    .arlen   (m_axi4_arlen),
    .arvalid (m_axi4_arvalid),
    .arready (m_axi4_arready),
    .rdata   (m_axi4_rdata),
    .rlast   (m_axi4_rlast),
    .rvalid  (m_axi4_rvalid),
    .rready  (m_axi4_rready)
  );

  // ------------------------------------------------------------------------
  // Reference model and checks
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory holds a/2 + k at coefficient k of byte address a
  function automatic logic [COEF_W-1:0] ref_coef(input int ks_loop, input int x, input int w,
                                                 input int j, input int cut, input int f);
    logic [ADD_W-1:0] a;
    int               k;
    a = BASE_ADD + ADD_W'(ks_loop * `KSK_SLICE_BYTES + (x * WPC + w) * WORD_BYTES);
    k = (j * `KSK_CUT_NB + cut) * FC + f;
    return COEF_W'((a >> 1) + ADD_W'(k));
  endfunction

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Queue the bursts, writes and done pulse that one command must produce
  task automatic expect_cmd(input int slot, input int ks_loop);
    int               col_nb;
    int               remain;
    int               room;
    int               n;
    logic [ADD_W-1:0] a;
    ar_rec_t          ar;
    wr_rec_t          rec;
    col_nb = (ks_loop == `KSK_COL_NB - 1) ? `KSK_LBX_LAST : `KSK_LBX;
    for (int x = 0; x < col_nb; x++) begin
      a      = BASE_ADD + ADD_W'(ks_loop * `KSK_SLICE_BYTES + x * WPC * WORD_BYTES);
      remain = WPC;
      while (remain > 0) begin
        room   = (PAGE_BYTES - int'(a[`KSK_PAGE_BYTES_W-1:0])) / WORD_BYTES;
        n      = (room < remain) ? room : remain;
        ar.add = a;
        ar.len = 8'(n - 1);
        exp_ar.push_back(ar);
        a      = a + ADD_W'(n * WORD_BYTES);
        remain = remain - n;
      end
      for (int w = 0; w < WPC; w++) begin
        for (int j = 0; j < WPW; j++) begin
          for (int c = 0; c < `KSK_CUT_NB; c++) begin
            for (int f = 0; f < FC; f++) begin
              rec.data[(c*FC + f)*COEF_W +: COEF_W] = ref_coef(ks_loop, x, w, j, c, f);
            end
          end
          rec.add     = RAM_ADD_W'(slot * `KSK_SLOT_DEPTH + (x * WPC + w) * WPW + j);
          rec.x_idx   = X_W'(x);
          rec.slot    = SLOT_W'(slot);
          rec.ks_loop = LOOP_W'(ks_loop);
          exp_wr.push_back(rec);
        end
      end
    end
    exp_done_slot.push_back(SLOT_W'(slot));
    exp_done_cnt.push_back(col_nb * WPC * WPW);
  endtask

  always @(posedge clk) begin
    if (s_rst_n) begin
      if (cctrl_rd_vld && cctrl_rd_rdy) cmd_acc++;

      if (m_axi4_arvalid && m_axi4_arready) begin
        if (exp_ar.size() == 0) abort_run("AR burst issued with no burst expected");
        ar_exp     = exp_ar.pop_front();
        burst_last = m_axi4_araddr + ADD_W'((int'(m_axi4_arlen) + 1) * WORD_BYTES - 1);
        check_val("m_axi4_araddr byte offset", 64'(m_axi4_araddr[`KSK_AXI_BYTES_W-1:0]),
                  64'(0));
        check_val("m_axi4_araddr", 64'(m_axi4_araddr), 64'(ar_exp.add));
        check_val("m_axi4_arlen", 64'(m_axi4_arlen), 64'(ar_exp.len));
        check_val("m_axi4_arid", 64'(m_axi4_arid), 64'(0));
        check_val("m_axi4_arsize", 64'(m_axi4_arsize), 64'($clog2(WORD_BYTES)));
        check_val("m_axi4_arburst", 64'(m_axi4_arburst), 64'(1));
        check_val("burst last byte page", 64'(burst_last >> `KSK_PAGE_BYTES_W),
                  64'(m_axi4_araddr >> `KSK_PAGE_BYTES_W));
      end

      if (ksk_mgr_wr_en != '0) begin
        if (exp_wr.size() == 0) abort_run("manager write with no write expected");
        wr_exp = exp_wr.pop_front();
        check_val("ksk_mgr_wr_en", 64'(ksk_mgr_wr_en), 64'((1 << `KSK_CUT_NB) - 1));
        check_val("ksk_mgr_wr_data", 64'(ksk_mgr_wr_data), 64'(wr_exp.data));
        check_val("ksk_mgr_wr_add", 64'(ksk_mgr_wr_add), 64'(wr_exp.add));
        check_val("ksk_mgr_wr_x_idx", 64'(ksk_mgr_wr_x_idx), 64'(wr_exp.x_idx));
        check_val("ksk_mgr_wr_slot", 64'(ksk_mgr_wr_slot), 64'(wr_exp.slot));
        check_val("ksk_mgr_wr_ks_loop", 64'(ksk_mgr_wr_ks_loop), 64'(wr_exp.ks_loop));
        wr_seen++;
      end

      // Done comes with the last write of the slice
      if (rd_slot_done) begin
        if (exp_done_slot.size() == 0) abort_run("rd_slot_done with no command pending");
        check_val("ksk_mgr_wr_en at rd_slot_done", 64'(|ksk_mgr_wr_en), 64'(1));
        check_val("rd_slot_id", 64'(rd_slot_id), 64'(exp_done_slot.pop_front()));
        check_val("writes per slice", 64'(wr_seen), 64'(exp_done_cnt.pop_front()));
        wr_seen = 0;
        done_seen++;
      end

      if (cmd_acc - done_seen > max_in_flight) max_in_flight = cmd_acc - done_seen;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic send_cmd(input int slot, input int ks_loop);
    int cycles;
    @(negedge clk);
    expect_cmd(slot, ks_loop);
    cctrl_rd_vld         = 1'b1;
    cctrl_rd_cmd.slot_id = SLOT_W'(slot);
    cctrl_rd_cmd.ks_loop = LOOP_W'(ks_loop);
    cycles = 0;
    while (!cctrl_rd_rdy) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("timeout waiting for cctrl_rd_rdy");
    end
    @(posedge clk);
  endtask

  task automatic end_cmds();
    @(negedge clk);
    cctrl_rd_vld = 1'b0;
  endtask

  task automatic wait_slices_done();
    int cycles;
    cycles = 0;
    while (exp_done_slot.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("timeout waiting for rd_slot_done");
    end
  endtask

  task automatic check_quiet(input string when);
    check_val({"m_axi4_arvalid ", when}, 64'(m_axi4_arvalid), 64'(0));
    check_val({"ksk_mgr_wr_en ", when}, 64'(ksk_mgr_wr_en), 64'(0));
    check_val({"rd_slot_done ", when}, 64'(rd_slot_done), 64'(0));
  endtask

  initial begin
    s_rst_n      = 1'b0;
    ksk_mem_addr = BASE_ADD;
    cctrl_rd_vld = 1'b0;
    cctrl_rd_cmd = '0;
    repeat (5) @(negedge clk);
    check_quiet("in reset");
    check_val("cctrl_rd_rdy in reset", 64'(cctrl_rd_rdy), 64'(0));
    check_val("m_axi4_rready in reset", 64'(m_axi4_rready), 64'(0));
    s_rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_quiet("before first command");
    end

    // One slice at a time and then the short last ks_loop
    send_cmd(1, 0);
    end_cmds();
    wait_slices_done();
    send_cmd(2, 15);
    end_cmds();
    wait_slices_done();

    // Back-to-back commands keep several in flight
    send_cmd(0, 1);
    send_cmd(3, 7);
    send_cmd(1, 15);
    send_cmd(2, 4);
    end_cmds();
    wait_slices_done();
    check_val("more than one command in flight", 64'(max_in_flight > 1), 64'(1));

    for (int i = 0; i < 6; i++) begin
      seed = lcg_next(seed);
      send_cmd(int'(seed[31:30]), int'(seed[27:24]));
    end
    end_cmds();
    wait_slices_done();

    check_val("AR bursts left over", 64'(exp_ar.size()), 64'(0));
    check_val("writes left over", 64'(exp_wr.size()), 64'(0));
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
ksk_rd_pkg.sv
ksk_rd_fifo.sv
ksk_rd_cmd_decode.sv
ksk_rd_req_gen.sv
ksk_rd_unpack.sv
ksk_axi_reader.sv
tb_axi_mem_model.sv
tb_ksk_axi_reader.sv
